// File: mand_fix_pkg.sv
`default_nettype none

package mand_fix_pkg;

  // Signed Q4.28 coordinate
  typedef logic signed [31:0] coord_t;

  // x*x + y*y as unsigned Q8.28
  typedef logic [35:0] mag_t;

  typedef logic [7:0]  iter_t;
  typedef logic [15:0] tag_t;

  localparam int FRAC_BITS = 28;
  localparam int LANE_LAT  = 2;    // Cycles from lane input to lane output

  localparam iter_t MAX_ITER   = 8'd255;
  localparam mag_t  ESCAPE_MAG = 36'd4 << FRAC_BITS;  // 4.0

endpackage

`default_nettype wire

// File: mand_bus_pkg.sv
`default_nettype none

package mand_bus_pkg;

  typedef logic [2:0]  adr_t;
  typedef logic [31:0] data_t;
  typedef logic [4:0]  fill_t;

  // Register map
  localparam adr_t ADR_X0      = 3'd0;
  localparam adr_t ADR_Y0      = 3'd1;
  localparam adr_t ADR_TAG     = 3'd2;
  localparam adr_t ADR_RES_TAG = 3'd3;
  localparam adr_t ADR_RES_CNT = 3'd4;
  localparam adr_t ADR_CMD     = 3'd7;

  localparam int CMD_PUSH  = 0;   // Bit index in a command write
  localparam int JOB_DEPTH = 16;

  // Job record is x0, y0, xn, yn, count, tag
  localparam int job_w = 4 * $bits(mand_fix_pkg::coord_t) + $bits(mand_fix_pkg::iter_t)
                         + $bits(mand_fix_pkg::tag_t);
  // Result record is tag, count
  localparam int res_w = $bits(mand_fix_pkg::tag_t) + $bits(mand_fix_pkg::iter_t);

endpackage

`default_nettype wire

// File: mand_fifo.sv
`default_nettype none

module mand_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  wire                 clk_i,
  input  wire                 rst_i,
  input  wire                 wr_i,
  input  wire                 rd_i,
  input  wire [WIDTH-1:0]     data_i,
  output logic [WIDTH-1:0]    q_o,
  output logic                empty_o,
  output mand_bus_pkg::fill_t used_o
);
  import mand_bus_pkg::*;

  localparam int AW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  fill_t            count;

  assign q_o     = mem[rd_ptr];   // Head is visible without a read
  assign empty_o = (count == '0);
  assign used_o  = count;

  always_ff @(posedge clk_i)
  begin
    if (wr_i)
      mem[wr_ptr] <= data_i;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_i)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_i)
        rd_ptr <= rd_ptr + 1'b1;
      if (wr_i && !rd_i)
        count <= count + 1'b1;
      else if (rd_i && !wr_i)
        count <= count - 1'b1;
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i) wr_i |-> count != DEPTH);
  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i) rd_i |-> !empty_o);

endmodule

`default_nettype wire

// File: mand_re_lane.sv
`default_nettype none

module mand_re_lane (
  input  wire                       clk_i,
  input  wire                       rst_i,
  input  wire                       valid_i,
  input  wire mand_fix_pkg::coord_t x_i,
  input  wire mand_fix_pkg::coord_t y_i,
  input  wire mand_fix_pkg::coord_t x0_i,
  output logic                      valid_o,
  output mand_fix_pkg::coord_t      x_next_o,
  output mand_fix_pkg::mag_t        mag_o
);
  import mand_fix_pkg::*;

  logic               v1_q;
  logic signed [63:0] xx_q;
  logic signed [63:0] yy_q;
  coord_t             x0_q;
  coord_t             xx_fix;
  coord_t             yy_fix;
  logic [63:0]        mag_sum;

  assign xx_fix  = xx_q[FRAC_BITS+31:FRAC_BITS];
  assign yy_fix  = yy_q[FRAC_BITS+31:FRAC_BITS];
  assign mag_sum = xx_q + yy_q;  // Both squares are non-negative

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      v1_q    <= 1'b0;
      valid_o <= 1'b0;
    end
    else
    begin
      v1_q    <= valid_i;
      valid_o <= v1_q;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (valid_i)
    begin
      xx_q <= x_i * x_i;
      yy_q <= y_i * y_i;
      x0_q <= x0_i;
    end
    if (v1_q)
    begin
      x_next_o <= xx_fix - yy_fix + x0_q;  // Wraps to 32 bits
      mag_o    <= mag_sum[FRAC_BITS+35:FRAC_BITS];
    end
  end

endmodule

`default_nettype wire

// File: mand_im_lane.sv
`default_nettype none

module mand_im_lane (
  input  wire                       clk_i,
  input  wire                       rst_i,
  input  wire                       valid_i,
  input  wire mand_fix_pkg::coord_t x_i,
  input  wire mand_fix_pkg::coord_t y_i,
  input  wire mand_fix_pkg::coord_t x0_i,
  input  wire mand_fix_pkg::coord_t y0_i,
  input  wire mand_fix_pkg::iter_t  count_i,
  input  wire mand_fix_pkg::tag_t   tag_i,
  output logic                      valid_o,
  output mand_fix_pkg::coord_t      y_next_o,
  output mand_fix_pkg::coord_t      x0_o,
  output mand_fix_pkg::coord_t      y0_o,
  output mand_fix_pkg::iter_t       count_o,
  output mand_fix_pkg::tag_t        tag_o
);
  import mand_fix_pkg::*;

  logic               v1_q;
  logic signed [63:0] xy_q;
  coord_t             x0_q;
  coord_t             y0_q;
  iter_t              count_q;
  tag_t               tag_q;
  coord_t             xy_fix;

  assign xy_fix = xy_q[FRAC_BITS+31:FRAC_BITS];

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      v1_q    <= 1'b0;
      valid_o <= 1'b0;
    end
    else
    begin
      v1_q    <= valid_i;
      valid_o <= v1_q;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (valid_i)
    begin
      xy_q    <= x_i * y_i;
      x0_q    <= x0_i;
      y0_q    <= y0_i;
      count_q <= count_i;
      tag_q   <= tag_i;
    end
    if (v1_q)
    begin
      y_next_o <= (xy_fix <<< 1) + y0_q;  // 2xy + y0, wraps
      x0_o     <= x0_q;
      y0_o     <= y0_q;
      count_o  <= count_q;
      tag_o    <= tag_q;
    end
  end

endmodule

`default_nettype wire

// File: mand_step.sv
`default_nettype none

module mand_step (
  input  wire                       clk_i,
  input  wire                       rst_i,
  input  wire                       re_valid_i,
  input  wire                       im_valid_i,
  input  wire mand_fix_pkg::coord_t x_next_i,
  input  wire mand_fix_pkg::coord_t y_next_i,
  input  wire mand_fix_pkg::coord_t x0_i,
  input  wire mand_fix_pkg::coord_t y0_i,
  input  wire mand_fix_pkg::mag_t   mag_i,
  input  wire mand_fix_pkg::iter_t  count_i,
  input  wire mand_fix_pkg::tag_t   tag_i,
  output logic                      step_valid_o,
  output logic                      done_o,
  output mand_fix_pkg::coord_t      x0_o,
  output mand_fix_pkg::coord_t      y0_o,
  output mand_fix_pkg::coord_t      xn_o,
  output mand_fix_pkg::coord_t      yn_o,
  output mand_fix_pkg::iter_t       count_o,
  output mand_fix_pkg::tag_t        tag_o
);
  import mand_fix_pkg::*;

  logic escaped;
  logic at_limit;

  // Magnitude comes from the old z
  assign escaped  = (mag_i > ESCAPE_MAG);
  assign at_limit = (count_i == MAX_ITER);

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      step_valid_o <= 1'b0;
    else
      step_valid_o <= re_valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (re_valid_i)
    begin
      done_o <= escaped || at_limit;
      x0_o   <= x0_i;
      y0_o   <= y0_i;
      xn_o   <= x_next_i;
      yn_o   <= y_next_i;
      tag_o  <= tag_i;
      if (escaped || at_limit)
        count_o <= count_i;  // Finished count stays
      else
        count_o <= count_i + 1'b1;
    end
  end

  // Both lanes were fed by the same issue pulse
  a_lanes_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
    re_valid_i == im_valid_i);

endmodule

`default_nettype wire

// File: mand_ctrl.sv
`default_nettype none

module mand_ctrl (
  input  wire                             clk_i,
  input  wire                             rst_i,
  input  wire                             cyc_i,
  input  wire                             stb_i,
  input  wire                             we_i,
  input  wire mand_bus_pkg::adr_t         adr_i,
  input  wire mand_bus_pkg::data_t        dat_i,
  output mand_bus_pkg::data_t             dat_o,
  output logic                            ack_o,
  output logic                            job_wr_o,
  output logic [mand_bus_pkg::job_w-1:0]  job_data_o,
  output logic                            job_rd_o,
  input  wire [mand_bus_pkg::job_w-1:0]   job_q_i,
  input  wire                             job_empty_i,
  output logic                            issue_valid_o,
  output mand_fix_pkg::coord_t            issue_x_o,
  output mand_fix_pkg::coord_t            issue_y_o,
  output mand_fix_pkg::coord_t            issue_x0_o,
  output mand_fix_pkg::coord_t            issue_y0_o,
  output mand_fix_pkg::iter_t             issue_count_o,
  output mand_fix_pkg::tag_t              issue_tag_o,
  output logic                            loop_rd_o,
  input  wire [mand_bus_pkg::job_w:0]     loop_q_i,
  input  wire                             loop_empty_i,
  output logic                            res_wr_o,
  output logic [mand_bus_pkg::res_w-1:0]  res_data_o,
  output logic                            res_rd_o,
  input  wire [mand_bus_pkg::res_w-1:0]   res_q_i,
  input  wire                             res_empty_i,
  input  wire mand_bus_pkg::fill_t        res_used_i
);
  import mand_fix_pkg::*;
  import mand_bus_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_ACCESS, ST_WAIT_PUSH, ST_DONE} bus_state_t;

  bus_state_t state;
  bus_state_t state_next;
  coord_t     x0_q;
  coord_t     y0_q;
  tag_t       tag_q;
  tag_t       res_tag_q;
  iter_t      res_cnt_q;
  fill_t      jobs_q;        // Accepted and not yet popped
  data_t      rd_data;
  logic       is_cmd;
  logic       recirc;
  logic       push_ok;
  logic       do_pop;
  logic       loop_done;
  coord_t     loop_x0;
  coord_t     loop_y0;
  coord_t     loop_xn;
  coord_t     loop_yn;
  iter_t      loop_count;
  tag_t       loop_tag;

  // Head of the job FIFO goes straight to both lanes
  assign {issue_x0_o, issue_y0_o, issue_x_o, issue_y_o, issue_count_o, issue_tag_o} = job_q_i;
  assign issue_valid_o = !job_empty_i;
  assign job_rd_o      = !job_empty_i;

  assign {loop_done, loop_x0, loop_y0, loop_xn, loop_yn, loop_count, loop_tag} = loop_q_i;
  assign loop_rd_o  = !loop_empty_i;
  assign recirc     = !loop_empty_i && !loop_done;
  assign res_wr_o   = !loop_empty_i && loop_done;
  assign res_data_o = {loop_tag, loop_count};

  // Recirculation wins the job FIFO write port
  assign push_ok  = (state == ST_WAIT_PUSH) && !recirc && (jobs_q != JOB_DEPTH);
  assign job_wr_o = recirc || push_ok;
  always_comb
  begin
    if (recirc)
      job_data_o = {loop_x0, loop_y0, loop_xn, loop_yn, loop_count, loop_tag};
    else
      job_data_o = {x0_q, y0_q, coord_t'(0), coord_t'(0), iter_t'(0), tag_q};
  end

  assign is_cmd   = (adr_i == ADR_CMD);
  assign do_pop   = (state == ST_ACCESS) && we_i && is_cmd && !dat_i[CMD_PUSH] && !res_empty_i;
  assign res_rd_o = do_pop;
  assign ack_o    = (state == ST_DONE);

  always_comb
  begin
    case (adr_i)
      ADR_X0:      rd_data = x0_q;
      ADR_Y0:      rd_data = y0_q;
      ADR_TAG:     rd_data = data_t'(tag_q);
      ADR_RES_TAG: rd_data = data_t'(res_tag_q);
      ADR_RES_CNT: rd_data = data_t'(res_cnt_q);
      ADR_CMD:     rd_data = data_t'(res_used_i);  // Results waiting
      default:     rd_data = '0;
    endcase
  end

  always_comb
  begin
    state_next = state;
    case (state)
      ST_IDLE:
        if (cyc_i && stb_i)
          state_next = ST_ACCESS;
      ST_ACCESS:
        if (we_i && is_cmd && dat_i[CMD_PUSH])
          state_next = ST_WAIT_PUSH;
        else
          state_next = ST_DONE;
      ST_WAIT_PUSH:
        if (push_ok)
          state_next = ST_DONE;
      default:
        state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state     <= ST_IDLE;
      x0_q      <= '0;
      y0_q      <= '0;
      tag_q     <= '0;
      res_tag_q <= '0;
      res_cnt_q <= '0;
      jobs_q    <= '0;
      dat_o     <= '0;
    end
    else
    begin
      state <= state_next;
      if (state == ST_ACCESS && we_i)
      begin
        case (adr_i)
          ADR_X0:  x0_q  <= dat_i;
          ADR_Y0:  y0_q  <= dat_i;
          ADR_TAG: tag_q <= dat_i[$bits(tag_t)-1:0];
          default: ;
        endcase
      end
      else if (state == ST_ACCESS)
        dat_o <= rd_data;
      if (do_pop)
      begin
        res_tag_q <= res_q_i[res_w-1:$bits(iter_t)];
        res_cnt_q <= res_q_i[$bits(iter_t)-1:0];
      end
      if (push_ok)
        jobs_q <= jobs_q + 1'b1;
      else if (do_pop)
        jobs_q <= jobs_q - 1'b1;
    end
  end

  a_ack_single: assert property (@(posedge clk_i) disable iff (rst_i) ack_o |=> !ack_o);

endmodule

`default_nettype wire

// File: mand_unit.sv
`default_nettype none

module mand_unit (
  input  wire                      clk_i,
  input  wire                      rst_i,
  input  wire                      cyc_i,
  input  wire                      stb_i,
  input  wire                      we_i,
  input  wire mand_bus_pkg::adr_t  adr_i,
  input  wire mand_bus_pkg::data_t dat_i,
  output mand_bus_pkg::data_t      dat_o,
  output logic                     ack_o
);
  import mand_fix_pkg::*;
  import mand_bus_pkg::*;

  logic             job_wr, job_rd, job_empty;
  logic [job_w-1:0] job_data, job_q;
  logic             loop_rd, loop_empty;
  logic [job_w:0]   loop_q;
  logic             res_wr, res_rd, res_empty;
  logic [res_w-1:0] res_data, res_q;
  fill_t            res_used;

  logic   issue_valid;
  coord_t issue_x, issue_y, issue_x0, issue_y0;
  iter_t  issue_count;
  tag_t   issue_tag;

  logic   re_valid, im_valid;
  coord_t re_x_next, im_y_next, im_x0, im_y0;
  mag_t   re_mag;
  iter_t  im_count;
  tag_t   im_tag;

  logic   step_valid, step_done;
  coord_t step_x0, step_y0, step_xn, step_yn;
  iter_t  step_count;
  tag_t   step_tag;

  mand_ctrl i_ctrl (
    .clk_i(clk_i), .rst_i(rst_i), .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i),
    .adr_i(adr_i), .dat_i(dat_i), .dat_o(dat_o), .ack_o(ack_o),
    .job_wr_o(job_wr), .job_data_o(job_data), .job_rd_o(job_rd),
    .job_q_i(job_q), .job_empty_i(job_empty),
    .issue_valid_o(issue_valid), .issue_x_o(issue_x), .issue_y_o(issue_y),
    .issue_x0_o(issue_x0), .issue_y0_o(issue_y0),
    .issue_count_o(issue_count), .issue_tag_o(issue_tag),
    .loop_rd_o(loop_rd), .loop_q_i(loop_q), .loop_empty_i(loop_empty),
    .res_wr_o(res_wr), .res_data_o(res_data), .res_rd_o(res_rd),
    .res_q_i(res_q), .res_empty_i(res_empty), .res_used_i(res_used)
  );

  mand_fifo #(.WIDTH(job_w), .DEPTH(JOB_DEPTH)) job_fifo (
    .clk_i(clk_i), .rst_i(rst_i), .wr_i(job_wr), .rd_i(job_rd),
    .data_i(job_data), .q_o(job_q), .empty_o(job_empty), .used_o()
  );

  // Stepped record with its done flag on top
  mand_fifo #(.WIDTH(job_w + 1), .DEPTH(JOB_DEPTH)) loop_fifo (
    .clk_i(clk_i), .rst_i(rst_i), .wr_i(step_valid), .rd_i(loop_rd),
    .data_i({step_done, step_x0, step_y0, step_xn, step_yn, step_count, step_tag}),
    .q_o(loop_q), .empty_o(loop_empty), .used_o()
  );

  mand_fifo #(.WIDTH(res_w), .DEPTH(JOB_DEPTH)) res_fifo (
    .clk_i(clk_i), .rst_i(rst_i), .wr_i(res_wr), .rd_i(res_rd),
    .data_i(res_data), .q_o(res_q), .empty_o(res_empty), .used_o(res_used)
  );

  mand_re_lane i_re_lane (
    .clk_i(clk_i), .rst_i(rst_i), .valid_i(issue_valid),
    .x_i(issue_x), .y_i(issue_y), .x0_i(issue_x0),
    .valid_o(re_valid), .x_next_o(re_x_next), .mag_o(re_mag)
  );

  mand_im_lane i_im_lane (
    .clk_i(clk_i), .rst_i(rst_i), .valid_i(issue_valid),
    .x_i(issue_x), .y_i(issue_y), .x0_i(issue_x0), .y0_i(issue_y0),
    .count_i(issue_count), .tag_i(issue_tag),
    .valid_o(im_valid), .y_next_o(im_y_next), .x0_o(im_x0), .y0_o(im_y0),
    .count_o(im_count), .tag_o(im_tag)
  );

  mand_step i_step (
    .clk_i(clk_i), .rst_i(rst_i), .re_valid_i(re_valid), .im_valid_i(im_valid),
    .x_next_i(re_x_next), .y_next_i(im_y_next), .x0_i(im_x0), .y0_i(im_y0),
    .mag_i(re_mag), .count_i(im_count), .tag_i(im_tag),
    .step_valid_o(step_valid), .done_o(step_done),
    .x0_o(step_x0), .y0_o(step_y0), .xn_o(step_xn), .yn_o(step_yn),
    .count_o(step_count), .tag_o(step_tag)
  );

endmodule

`default_nettype wire

// File: tb_mand_unit.sv
`default_nettype none

module tb_mand_unit;
  import mand_fix_pkg::*;
  import mand_bus_pkg::*;

  logic  clk = 1'b0;
  logic  rst;
  logic  cyc;
  logic  stb;
  logic  we;
  adr_t  adr;
  data_t wdat;
  data_t rdat;
  logic  ack;

  // Parsed trace, one entry per operation
  logic [7:0] op_q [$];
  data_t      arg_q [$];
  data_t      dat_q [$];
  data_t      exp_q [$];
  int         n_ops = 0;
  int         op_idx;
  int         leftover;

  iter_t exp_cnt [0:65535];   // Expected count per tag
  logic  exp_vld [0:65535];   // Tag still has a result to come
  tag_t  last_tag;
  iter_t last_cnt;

  mand_unit i_mand_unit (
    .clk_i(clk), .rst_i(rst), .cyc_i(cyc), .stb_i(stb), .we_i(we),
    .adr_i(adr), .dat_i(wdat), .dat_o(rdat), .ack_o(ack)
  );

  always #10 clk = ~clk;

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp)
      fail_run($sformatf("FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_tag(input string name, input tag_t got, input tag_t exp);
    if (got !== exp)
      fail_run($sformatf("FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_count(input string name, input iter_t got, input iter_t exp);
    if (got !== exp)
      fail_run($sformatf("FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  // One bus cycle, held until ack
  task automatic bus_access(input logic write, input adr_t a, input data_t d, output data_t q);
    @(posedge clk);
    cyc  <= 1'b1;
    stb  <= 1'b1;
    we   <= write;
    adr  <= a;
    wdat <= d;
    @(negedge clk);
    while (!ack)
      @(negedge clk);
    q = rdat;  // Valid during the ack cycle
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic write_reg(input adr_t a, input data_t d);
    data_t discard;
    bus_access(1'b1, a, d, discard);
  endtask

  task automatic read_reg(input adr_t a, output data_t q);
    bus_access(1'b0, a, '0, q);
  endtask

  task automatic pop_result;
    data_t tag_word;
    data_t cnt_word;
    tag_t  tag;
    write_reg(ADR_CMD, '0);
    read_reg(ADR_RES_TAG, tag_word);
    read_reg(ADR_RES_CNT, cnt_word);
    tag = tag_word[$bits(tag_t)-1:0];
    if (!exp_vld[tag])
      fail_run($sformatf("Popped tag %h, which has no job waiting for it", tag));
    else
    begin
      check_count($sformatf("res_cnt of tag %h", tag), cnt_word[7:0], exp_cnt[tag]);
      exp_vld[tag] = 1'b0;
      last_tag = tag;
      last_cnt = cnt_word[7:0];
    end
  endtask

  task automatic run_op(input logic [7:0] op, input data_t arg, input data_t d, input data_t e);
    data_t q;
    tag_t  tag;
    int    k;
    case (op)
      "W": write_reg(adr_t'(arg), d);
      "R":
      begin
        read_reg(adr_t'(arg), q);
        check_data($sformatf("dat_o at address %0d", arg), q, e);
      end
      "P":
      begin
        read_reg(ADR_CMD, q);
        while (q != e)
        begin
          if (q > e)
            fail_run($sformatf("More results waiting than expected: %0d", q));
          else
            read_reg(ADR_CMD, q);
        end
      end
      "J":
        for (k = 0; k < arg; k++)
        begin
          tag = tag_t'(d + k);
          exp_cnt[tag] = iter_t'(e);
          exp_vld[tag] = 1'b1;
          write_reg(ADR_TAG, data_t'(tag));
          write_reg(ADR_CMD, data_t'(1) << CMD_PUSH);
        end
      "O":
        for (k = 0; k < arg; k++)
          pop_result();
      "E":
      begin
        write_reg(ADR_CMD, '0);  // Nothing to pop
        read_reg(ADR_RES_TAG, q);
        check_tag("res_tag after empty pop", q[$bits(tag_t)-1:0], last_tag);
        read_reg(ADR_RES_CNT, q);
        check_count("res_cnt after empty pop", q[7:0], last_cnt);
      end
      default: fail_run($sformatf("Unknown trace operation %c", op));
    endcase
  endtask

  task automatic read_trace;
    int         fd;
    int         code;
    int         ch;
    logic [7:0] op;
    data_t      arg;
    data_t      d;
    data_t      e;
    fd = $fopen("mand_trace.txt", "r");
    if (fd == 0)
      fail_run("Cannot open the trace file mand_trace.txt");
    else
    begin
      code = $fscanf(fd, " %c", op);
      while (code == 1)
      begin
        if (op == "#")
        begin
          ch = $fgetc(fd);  // Skip a comment line
          while (ch != 10 && ch != -1)
            ch = $fgetc(fd);
        end
        else if ($fscanf(fd, " %h %h %h", arg, d, e) != 3)
          fail_run($sformatf("Malformed trace line for operation %c", op));
        else
        begin
          op_q.push_back(op);
          arg_q.push_back(arg);
          dat_q.push_back(d);
          exp_q.push_back(e);
        end
        code = $fscanf(fd, " %c", op);
      end
      $fclose(fd);
    end
  endtask

  initial
  begin
    rst  = 1'b1;
    cyc  = 1'b0;
    stb  = 1'b0;
    we   = 1'b0;
    adr  = '0;
    wdat = '0;
    last_tag = '0;  // Result registers come out of reset as 0
    last_cnt = '0;
    for (op_idx = 0; op_idx < 65536; op_idx++)
      exp_vld[op_idx] = 1'b0;
    read_trace();
    n_ops = op_q.size();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    for (op_idx = 0; op_idx < n_ops; op_idx++)
      run_op(op_q[op_idx], arg_q[op_idx], dat_q[op_idx], exp_q[op_idx]);
    leftover = 0;
    for (op_idx = 0; op_idx < 65536; op_idx++)
      if (exp_vld[op_idx])
        leftover++;
    if (n_ops != 0 && leftover == 0)
    begin
      $display("Regression passed");
      $finish;
    end
    else
      fail_run($sformatf("Trace empty or %0d results never popped", leftover));
  end

  // Watchdog, 400 cycles per trace operation
  initial
  begin
    wait (n_ops > 0);
    #(n_ops * 400 * 20);
    fail_run("Run timed out before the trace was finished");
  end

endmodule

`default_nettype wire

// File: list.f
mand_fix_pkg.sv
mand_bus_pkg.sv
mand_fifo.sv
mand_re_lane.sv
mand_im_lane.sv
mand_step.sv
mand_ctrl.sv
mand_unit.sv
tb_mand_unit.sv

// File: mand_trace.txt
# op arg data expect, numbers in hex
# W write reg arg, R read reg arg, P poll results waiting, J push arg jobs from tag data, O pop arg, E pop when empty
R 7 0 0
E 0 0 0
W 0 12345678 0
W 1 9abcdef0 0
W 2 0000beef 0
R 0 0 12345678
R 1 0 9abcdef0
R 2 0 0000beef
W 0 00000000 0
W 1 00000000 0
J 1 0001 ff
P 0 0 1
O 1 0 0
E 0 0 0
R 7 0 0
W 0 10000000 0
J 1 0002 3
P 0 0 1
O 1 0 0
R 2 0 00000002
W 0 08000000 0
J 1 0010 5
W 0 10000000 0
W 1 10000000 0
J 1 0011 2
W 0 00000000 0
J 1 0012 ff
W 0 28000000 0
W 1 08000000 0
J 1 0013 1
W 0 e0000000 0
W 1 00000000 0
J 1 0014 ff
W 0 30000000 0
J 1 0015 1
W 0 00000000 0
W 1 20000000 0
J 1 0016 2
W 0 04000000 0
W 1 00000000 0
J 1 0017 ff
P 0 0 8
O 8 0 0
E 0 0 0
R 7 0 0
W 0 f0000000 0
J 8 0020 ff
W 0 30000000 0
J 8 0028 1
P 0 0 10
O 1 0 0
J 1 0030 1
P 0 0 10
O 10 0 0
R 7 0 0
E 0 0 0
